/* mulIssue_defs.svh */
// Multiply issue slice constants
`ifndef MULISSUE_DEFS_SVH
`define MULISSUE_DEFS_SVH

// ============================================================
// Data path
// ============================================================

// Operand and result width of the slice
`define MUL_DATA_W 32

// ============================================================
// Micro-op word layout
// ============================================================

// Opcode sits in the low seven bits
`define UOP_OPCODE_LSB 0
`define UOP_OPCODE_W 7

// Function code for the R3 register forms
`define UOP_FUNC_LSB 28
`define UOP_FUNC_W 4

// Sixteen bit immediate used by MULI
`define UOP_IMM_LSB 12
`define UOP_IMM_W 16

// ============================================================
// APB register map
// ============================================================

`define REG_SRCA 5'h00
`define REG_SRCB 5'h04
`define REG_UOP 5'h08
`define REG_RESULT 5'h0C
`define REG_STATUS 5'h10
`define REG_COUNT 5'h14
`define REG_CTRL 5'h18

`endif

/* mulIssuePkg.sv */
// Multiply issue slice types
`default_nettype none

`include "mulIssue_defs.svh"

package mulIssuePkg;

	// ============================================================
	// Micro-op encodings
	// ============================================================

	// Opcodes the slice knows about
	// Only MULI and the R3 byte, wyde and tetra forms can be issued
	// R3O and ADDI are recognised but always rejected by the decoder
	typedef enum logic [`UOP_OPCODE_W-1:0]
	{
		OP_R3B = 7'h02,
		OP_R3W = 7'h03,
		OP_R3T = 7'h04,
		OP_R3O = 7'h05,
		OP_ADDI = 7'h10,
		OP_MULI = 7'h16
	} opcode_t;

	// Function codes carried by the R3 forms
	// A register form is a multiply only when func is FN_MUL
	typedef enum logic [`UOP_FUNC_W-1:0]
	{
		FN_ADD = 4'h0,
		FN_SUB = 4'h1,
		FN_MUL = 4'h6,
		FN_AND = 4'h8
	} func_t;

	// ============================================================
	// Multiplier types
	// ============================================================

	// Operand size, which also sets the iteration count
	// Byte runs 8 steps, wyde 16 steps and tetra 32 steps
	typedef enum logic [1:0]
	{
		SZ_BYTE = 2'd0,
		SZ_WYDE = 2'd1,
		SZ_TETRA = 2'd2
	} mulSize_t;

	// Multiplier sequencer states
	// RUN does one shift-add step per cycle, FINISH fixes sign and size
	typedef enum logic [1:0]
	{
		IDLE = 2'd0,
		RUN = 2'd1,
		FINISH = 2'd2
	} mulState_t;

endpackage

`default_nettype wire

/* decodeMul.sv */
// Multiply micro-op decoder
`default_nettype none

`include "mulIssue_defs.svh"

module decodeMul import mulIssuePkg::*;
(
	input logic [`MUL_DATA_W-1:0] uop,
	output logic isMul,
	output logic useImm,
	output mulSize_t size,
	output logic [`MUL_DATA_W-1:0] immValue
);

	// Raw fields pulled out of the micro-op word
	opcode_t opcode;
	func_t func;
	logic [`UOP_IMM_W-1:0] immField;

	assign opcode = opcode_t'(uop[`UOP_OPCODE_LSB +: `UOP_OPCODE_W]);
	assign func = func_t'(uop[`UOP_FUNC_LSB +: `UOP_FUNC_W]);
	assign immField = uop[`UOP_IMM_LSB +: `UOP_IMM_W];

	// MULI is always a multiply
	// The register forms need FN_MUL in the func field
	// R3O is left out on purpose since the octa size is not built here
	function automatic logic fnIsMuls(input opcode_t op, input func_t fn);
		logic regForm;
		regForm = (op == OP_R3B) || (op == OP_R3W) || (op == OP_R3T);
		fnIsMuls = (op == OP_MULI) || (regForm && (fn == FN_MUL));
	endfunction

	assign isMul = fnIsMuls(opcode, func);

	// Only the immediate form takes operand B from the micro-op word
	assign useImm = (opcode == OP_MULI);

	// Map the opcode onto the operand size
	// Anything that is not a byte or wyde form runs at tetra size
	always_comb
	begin
		case (opcode)
			OP_R3B:
				size = SZ_BYTE;
			OP_R3W:
				size = SZ_WYDE;
			default:
				size = SZ_TETRA;
		endcase
	end

	// The immediate is signed, so it is widened with its top bit
	assign immValue = {{(`MUL_DATA_W - `UOP_IMM_W){immField[`UOP_IMM_W-1]}}, immField};

endmodule

`default_nettype wire

/* mulUnit.sv */
// Iterative signed multiplier
`default_nettype none

`include "mulIssue_defs.svh"

module mulUnit import mulIssuePkg::*;
(
	input logic clk,
	input logic rstN,
	input logic start,
	input logic [`MUL_DATA_W-1:0] srcA,
	input logic [`MUL_DATA_W-1:0] srcB,
	input logic [`MUL_DATA_W-1:0] immValue,
	input logic useImm,
	input mulSize_t size,
	output logic busy,
	output logic done,
	output logic [`MUL_DATA_W-1:0] product
);

	// ============================================================
	// Helpers
	// ============================================================

	// Sign-extend the low part of a value from the given size
	function automatic logic [`MUL_DATA_W-1:0] sextSize(input logic [`MUL_DATA_W-1:0] v,
		input mulSize_t sz);
		case (sz)
			SZ_BYTE:
				sextSize = {{(`MUL_DATA_W - 8){v[7]}}, v[7:0]};
			SZ_WYDE:
				sextSize = {{(`MUL_DATA_W - 16){v[15]}}, v[15:0]};
			default:
				sextSize = v;
		endcase
	endfunction

	// Number of shift-add steps for each size
	function automatic logic [5:0] stepsFor(input mulSize_t sz);
		case (sz)
			SZ_BYTE:
				stepsFor = 6'd8;
			SZ_WYDE:
				stepsFor = 6'd16;
			default:
				stepsFor = 6'd32;
		endcase
	endfunction

	// ============================================================
	// Operand preparation
	// ============================================================

	mulState_t state;
	logic [5:0] stepCnt;
	logic [`MUL_DATA_W-1:0] acc;
	logic [`MUL_DATA_W-1:0] mcand;
	logic [`MUL_DATA_W-1:0] mplier;
	logic negRes;
	mulSize_t sizeQ;

	logic [`MUL_DATA_W-1:0] opA;
	logic [`MUL_DATA_W-1:0] opB;
	logic [`MUL_DATA_W-1:0] magA;
	logic [`MUL_DATA_W-1:0] magB;
	logic [`MUL_DATA_W-1:0] signedProd;
	logic [`MUL_DATA_W-1:0] finalVal;

	// Operand B is the immediate for MULI and the register otherwise
	assign opA = sextSize(srcA, size);
	assign opB = sextSize(useImm ? immValue : srcB, size);

	// Magnitudes are taken after sign extension so every size shares one path
	// The most negative tetra still fits, since the magnitude is unsigned
	assign magA = opA[`MUL_DATA_W-1] ? (~opA + 1'b1) : opA;
	assign magB = opB[`MUL_DATA_W-1] ? (~opB + 1'b1) : opB;

	// Only the low bits matter, so negation modulo 2^32 gives the signed result
	assign signedProd = negRes ? (~acc + 1'b1) : acc;
	assign finalVal = sextSize(signedProd, sizeQ);

	// ============================================================
	// Sequencer
	// ============================================================

	// Start loads the operands, RUN takes N cycles, FINISH one more
	// This puts done N+2 cycles after the start pulse
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= IDLE;
			stepCnt <= 6'd0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				IDLE:
					if (start)
					begin
						state <= RUN;
						stepCnt <= stepsFor(size) - 6'd1;
					end
				RUN:
					if (stepCnt == 6'd0)
						state <= FINISH;
					else
						stepCnt <= stepCnt - 6'd1;
				FINISH:
				begin
					state <= IDLE;
					done <= 1'b1;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// ============================================================
	// Shift-add data path
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (state == IDLE && start)
		begin
			acc <= '0;
			mcand <= magA;
			mplier <= magB;
			negRes <= opA[`MUL_DATA_W-1] ^ opB[`MUL_DATA_W-1];
			sizeQ <= size;
		end
		else if (state == RUN)
		begin
			// One multiplier bit per cycle, lowest bit first
			if (mplier[0])
				acc <= acc + mcand;
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
		else if (state == FINISH)
			product <= finalVal;
	end

	assign busy = (state != IDLE);

endmodule

`default_nettype wire

/* mulRegs.sv */
// APB register block for the multiply slice
`default_nettype none

`include "mulIssue_defs.svh"

module mulRegs
(
	input logic clk,
	input logic rstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [4:0] paddr,
	input logic [`MUL_DATA_W-1:0] pwdata,
	output logic [`MUL_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic isMul,
	input logic busy,
	input logic done,
	input logic [`MUL_DATA_W-1:0] product,
	output logic [`MUL_DATA_W-1:0] uop,
	output logic [`MUL_DATA_W-1:0] srcA,
	output logic [`MUL_DATA_W-1:0] srcB,
	output logic start,
	output logic irq
);

	// ============================================================
	// Access decode
	// ============================================================

	logic access;
	logic wrAccess;
	logic mapped;
	logic roTarget;
	logic launchPending;
	logic [`MUL_DATA_W-1:0] result;
	logic [`MUL_DATA_W-1:0] count;
	logic doneFlag;
	logic rejected;
	logic overrun;
	logic ctrlIe;
	logic statusBusy;

	// Every transfer completes in its access phase
	assign pready = 1'b1;
	assign access = psel && penable;
	assign wrAccess = access && pwrite;

	always_comb
	begin
		case (paddr)
			`REG_SRCA, `REG_SRCB, `REG_UOP, `REG_RESULT,
			`REG_STATUS, `REG_COUNT, `REG_CTRL:
				mapped = 1'b1;
			default:
				mapped = 1'b0;
		endcase
	end

	// RESULT and COUNT are read only
	assign roTarget = (paddr == `REG_RESULT) || (paddr == `REG_COUNT);
	assign pslverr = access && (!mapped || (pwrite && roTarget));

	// ============================================================
	// Issue
	// ============================================================

	// The decoder looks at the stored word, so the launch decision is taken
	// one cycle after the write, when isMul reflects the new micro-op
	assign start = launchPending && isMul;

	// The launch cycle counts as busy so a poll never sees a gap
	assign statusBusy = busy || start;

	// ============================================================
	// Register updates
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			srcA <= '0;
			srcB <= '0;
			uop <= '0;
			result <= '0;
			count <= '0;
			doneFlag <= 1'b0;
			rejected <= 1'b0;
			overrun <= 1'b0;
			ctrlIe <= 1'b0;
			launchPending <= 1'b0;
			irq <= 1'b0;
		end
		else
		begin
			launchPending <= 1'b0;

			if (wrAccess)
			begin
				case (paddr)
					`REG_SRCA:
						srcA <= pwdata;
					`REG_SRCB:
						srcB <= pwdata;
					`REG_UOP:
						// A micro-op that arrives while the unit is occupied is dropped
						if (busy || launchPending)
							overrun <= 1'b1;
						else
						begin
							uop <= pwdata;
							launchPending <= 1'b1;
						end
					`REG_STATUS:
					begin
						// Sticky flags clear on a written one
						if (pwdata[1])
							doneFlag <= 1'b0;
						if (pwdata[2])
							rejected <= 1'b0;
						if (pwdata[3])
							overrun <= 1'b0;
					end
					`REG_CTRL:
						ctrlIe <= pwdata[0];
					default:
					begin
					end
				endcase
			end

			// Hardware events come last so they win over a clear in the same cycle
			if (launchPending && !isMul)
				rejected <= 1'b1;

			if (done)
			begin
				result <= product;
				count <= count + 1'b1;
				doneFlag <= 1'b1;
			end

			// Interrupt follows the DONE flag one cycle later
			irq <= doneFlag && ctrlIe;
		end
	end

	// ============================================================
	// Read mux
	// ============================================================

	always_comb
	begin
		case (paddr)
			`REG_SRCA:
				prdata = srcA;
			`REG_SRCB:
				prdata = srcB;
			`REG_UOP:
				prdata = uop;
			`REG_RESULT:
				prdata = result;
			`REG_STATUS:
				prdata = {{(`MUL_DATA_W - 4){1'b0}}, overrun, rejected, doneFlag, statusBusy};
			`REG_COUNT:
				prdata = count;
			`REG_CTRL:
				prdata = {{(`MUL_DATA_W - 1){1'b0}}, ctrlIe};
			default:
				prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* mulIssueTop.sv */
// Multiply issue slice top level
`default_nettype none

`include "mulIssue_defs.svh"

module mulIssueTop import mulIssuePkg::*;
(
	input logic clk,
	input logic rstN,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [4:0] paddr,
	input logic [`MUL_DATA_W-1:0] pwdata,
	output logic [`MUL_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic irq
);

	// Register block to decoder and multiplier
	logic [`MUL_DATA_W-1:0] uop;
	logic [`MUL_DATA_W-1:0] srcA;
	logic [`MUL_DATA_W-1:0] srcB;
	logic start;

	// Decoder outputs
	logic isMul;
	logic useImm;
	mulSize_t size;
	logic [`MUL_DATA_W-1:0] immValue;

	// Multiplier back to the register block
	logic busy;
	logic done;
	logic [`MUL_DATA_W-1:0] product;

	mulRegs uRegs
	(
		.clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .isMul(isMul), .busy(busy), .done(done),
		.product(product), .uop(uop), .srcA(srcA), .srcB(srcB),
		.start(start), .irq(irq)
	);

	decodeMul uDecode
	(
		.uop(uop), .isMul(isMul), .useImm(useImm), .size(size), .immValue(immValue)
	);

	mulUnit uMul
	(
		.clk(clk), .rstN(rstN), .start(start), .srcA(srcA), .srcB(srcB),
		.immValue(immValue), .useImm(useImm), .size(size), .busy(busy),
		.done(done), .product(product)
	);

endmodule

`default_nettype wire

/* mulIssue_checker.sv */
// Issue and completion assertions
`default_nettype none

module mulIssueChecker import mulIssuePkg::*;
(
	input logic clk,
	input logic rstN,
	input logic start,
	input logic busy,
	input logic done,
	input mulSize_t size
);

	// Running total of assertion failures, looked at by the testbench at the end
	int failCount = 0;

	// ============================================================
	// Issue
	// ============================================================

	// The register block may only launch into an idle multiplier
	startIdle: assert property (@(posedge clk) disable iff (!rstN) start |-> !busy)
	else
	begin
		failCount++;
		$error("start pulsed while the multiplier was busy");
	end

	// ============================================================
	// Completion
	// ============================================================

	// Done is a single-cycle pulse
	donePulse: assert property (@(posedge clk) disable iff (!rstN) done |=> !done)
	else
	begin
		failCount++;
		$error("done stayed high for more than one cycle");
	end

	// Latency is N+2 cycles from the launch, N being the operand width
	byteLatency: assert property (@(posedge clk) disable iff (!rstN)
		(start && size == SZ_BYTE) |-> ##10 done)
	else
	begin
		failCount++;
		$error("byte multiply did not finish after 10 cycles");
	end

	wydeLatency: assert property (@(posedge clk) disable iff (!rstN)
		(start && size == SZ_WYDE) |-> ##18 done)
	else
	begin
		failCount++;
		$error("wyde multiply did not finish after 18 cycles");
	end

	tetraLatency: assert property (@(posedge clk) disable iff (!rstN)
		(start && size == SZ_TETRA) |-> ##34 done)
	else
	begin
		failCount++;
		$error("tetra multiply did not finish after 34 cycles");
	end

endmodule

// Attach to the internal issue and completion signals of the top level
bind mulIssueTop mulIssueChecker uChecker
(
	.clk(clk), .rstN(rstN), .start(start), .busy(busy), .done(done), .size(size)
);

`default_nettype wire

/* mulIssueTb.sv */
// Multiply issue slice testbench
`default_nettype none

`include "mulIssue_defs.svh"

module mulIssueTb;

	// ============================================================
	// Encodings and stimulus table
	// ============================================================

	// Opcode and func values as the micro-op format defines them
	localparam logic [6:0] OP_R3B = 7'h02;
	localparam logic [6:0] OP_R3W = 7'h03;
	localparam logic [6:0] OP_R3T = 7'h04;
	localparam logic [6:0] OP_R3O = 7'h05;
	localparam logic [6:0] OP_ADDI = 7'h10;
	localparam logic [6:0] OP_MULI = 7'h16;
	localparam logic [3:0] FN_ADD = 4'h0;
	localparam logic [3:0] FN_MUL = 4'h6;
	localparam int NUM_ROWS = 12;

	// One micro-op with its operands and whether the slice should take it
	typedef struct packed
	{
		logic [6:0] op;
		logic [3:0] fn;
		logic [31:0] a;
		logic [31:0] b;
		logic [15:0] imm;
		logic accept;
	} stimRow_t;

	stimRow_t rows [NUM_ROWS];

	logic clk;
	logic rstN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [4:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic irq;

	integer seed;
	int errCount;
	int testCount;
	int failedTests;
	int testStartErrs;
	int expCount;
	logic [31:0] expResult;

	mulIssueTop dut
	(
		.clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .irq(irq)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	// ============================================================
	// Helpers
	// ============================================================

	task automatic checkVal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected);
			errCount++;
		end
	endtask

	// One APB transfer, setup then access, sampled mid-way through the access phase
	task automatic apbXfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
		input logic expErr, output logic [31:0] rdata);
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		checkVal("pready", {31'b0, pready}, 32'h1);
		checkVal("pslverr", {31'b0, pslverr}, {31'b0, expErr});
		rdata = prdata;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apbWrite(input logic [4:0] addr, input logic [31:0] data);
		logic [31:0] ignored;
		apbXfer(1'b1, addr, data, 1'b0, ignored);
	endtask

	task automatic readCheck(input string name, input logic [4:0] addr,
		input logic [31:0] expected);
		logic [31:0] value;
		apbXfer(1'b0, addr, 32'h0, 1'b0, value);
		checkVal(name, value, expected);
	endtask

	// Poll STATUS until BUSY drops
	task automatic waitIdle();
		logic [31:0] status;
		int polls;
		polls = 0;
		status = 32'h1;
		while (status[0] && polls < 100)
		begin
			apbXfer(1'b0, `REG_STATUS, 32'h0, 1'b0, status);
			polls++;
		end
		if (status[0])
		begin
			$display("Timeout: the multiplier stayed busy for %0d status polls", polls);
			errCount++;
		end
	endtask

	task automatic waitIrq();
		int cycles;
		cycles = 0;
		while (!irq && cycles < 200)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!irq)
		begin
			$display("Timeout: irq did not rise within %0d cycles", cycles);
			errCount++;
		end
	endtask

	// Micro-op word: func on top, then the immediate, five spare bits and the opcode
	function automatic logic [31:0] uopWord(input stimRow_t row);
		uopWord = {row.fn, row.imm, 5'b0, row.op};
	endfunction

	// Low part of the signed product at the operand size, widened with its sign
	function automatic logic [31:0] refProduct(input stimRow_t row);
		logic [31:0] opB;
		logic signed [63:0] wideA;
		logic signed [63:0] wideB;
		logic [63:0] full;
		opB = (row.op == OP_MULI) ? {{16{row.imm[15]}}, row.imm} : row.b;
		case (row.op)
			OP_R3B:
			begin
				wideA = {{56{row.a[7]}}, row.a[7:0]};
				wideB = {{56{opB[7]}}, opB[7:0]};
			end
			OP_R3W:
			begin
				wideA = {{48{row.a[15]}}, row.a[15:0]};
				wideB = {{48{opB[15]}}, opB[15:0]};
			end
			default:
			begin
				wideA = {{32{row.a[31]}}, row.a};
				wideB = {{32{opB[31]}}, opB};
			end
		endcase
		full = wideA * wideB;
		case (row.op)
			OP_R3B:
				refProduct = {{24{full[7]}}, full[7:0]};
			OP_R3W:
				refProduct = {{16{full[15]}}, full[15:0]};
			default:
				refProduct = full[31:0];
		endcase
	endfunction

	task automatic finishTest(input string name);
		testCount++;
		if (errCount == testStartErrs)
			$display("Test %0d %s: ok", testCount, name);
		else
		begin
			failedTests++;
			$display("Test %0d %s: %0d errors", testCount, name, errCount - testStartErrs);
		end
		testStartErrs = errCount;
	endtask

	// Issue one table row and check the result or the rejection
	task automatic runRow(input stimRow_t row);
		apbWrite(`REG_SRCA, row.a);
		apbWrite(`REG_SRCB, row.b);
		apbWrite(`REG_UOP, uopWord(row));
		waitIdle();
		if (row.accept)
		begin
			expCount++;
			expResult = refProduct(row);
			readCheck("RESULT", `REG_RESULT, expResult);
			readCheck("STATUS", `REG_STATUS, 32'h2);
			apbWrite(`REG_STATUS, 32'h2);
		end
		else
		begin
			// A rejected micro-op leaves the result alone and never shows BUSY
			readCheck("RESULT", `REG_RESULT, expResult);
			readCheck("STATUS", `REG_STATUS, 32'h4);
			apbWrite(`REG_STATUS, 32'h4);
		end
		readCheck("COUNT", `REG_COUNT, expCount);
		readCheck("STATUS", `REG_STATUS, 32'h0);
	endtask

	// ============================================================
	// Test sequence
	// ============================================================

	initial
	begin
		logic [31:0] value;
		int i;
		seed = 32'hb43a;
		errCount = 0;
		testCount = 0;
		failedTests = 0;
		testStartErrs = 0;
		expCount = 0;
		expResult = 32'h0;
		rstN = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 5'h0;
		pwdata = 32'h0;

		// Byte and wyde rows overflow their size on purpose
		rows[0] = '{OP_R3B, FN_MUL, 32'h0000_007f, 32'h0000_0003, 16'h0000, 1'b1};
		rows[1] = '{OP_R3B, FN_MUL, 32'hffff_ff80, 32'h0000_0002, 16'h0000, 1'b1};
		rows[2] = '{OP_R3B, FN_MUL, 32'h1234_5685, 32'habcd_ef07, 16'h0000, 1'b1};
		rows[3] = '{OP_R3W, FN_MUL, 32'h0000_7fff, 32'h0000_0002, 16'h0000, 1'b1};
		rows[4] = '{OP_R3W, FN_MUL, 32'hffff_8000, 32'hffff_ffff, 16'h0000, 1'b1};
		rows[5] = '{OP_R3T, FN_MUL, 32'h0001_2345, 32'hffff_fff0, 16'h0000, 1'b1};
		rows[6] = '{OP_R3T, FN_MUL, $random(seed), $random(seed), 16'h0000, 1'b1};
		// MULI must ignore SRCB, so it holds junk
		rows[7] = '{OP_MULI, FN_ADD, 32'h0000_0123, 32'h5555_aaaa, 16'hfff3, 1'b1};
		rows[8] = '{OP_MULI, FN_ADD, $random(seed), 32'h0000_0000, 16'h8001, 1'b1};
		rows[9] = '{OP_R3T, FN_ADD, 32'h0000_0007, 32'h0000_0009, 16'h0000, 1'b0};
		rows[10] = '{OP_R3O, FN_MUL, 32'h0000_0007, 32'h0000_0009, 16'h0000, 1'b0};
		rows[11] = '{OP_ADDI, FN_ADD, 32'h0000_0007, 32'h0000_0009, 16'h0042, 1'b0};

		repeat (3) @(posedge clk);
		#1;
		rstN = 1'b1;

		for (i = 0; i < 7; i++)
			readCheck("prdata", 5'(i * 4), 32'h0);
		finishTest("reset values");

		for (i = 0; i < NUM_ROWS; i++)
			runRow(rows[i]);
		finishTest("multiply table");

		// Second micro-op lands while the tetra multiply is still running
		apbWrite(`REG_SRCA, rows[5].a);
		apbWrite(`REG_SRCB, rows[5].b);
		apbWrite(`REG_UOP, uopWord(rows[5]));
		apbWrite(`REG_UOP, uopWord(rows[0]));
		readCheck("STATUS", `REG_STATUS, 32'h9);
		waitIdle();
		expCount++;
		readCheck("RESULT", `REG_RESULT, refProduct(rows[5]));
		readCheck("UOP", `REG_UOP, uopWord(rows[5]));
		readCheck("COUNT", `REG_COUNT, expCount);
		finishTest("overrun");

		readCheck("COUNT", `REG_COUNT, expCount);
		readCheck("STATUS", `REG_STATUS, 32'ha);
		apbWrite(`REG_STATUS, 32'he);
		readCheck("STATUS", `REG_STATUS, 32'h0);
		finishTest("count and flag clear");

		apbWrite(`REG_CTRL, 32'h1);
		apbWrite(`REG_SRCA, rows[0].a);
		apbWrite(`REG_SRCB, rows[0].b);
		apbWrite(`REG_UOP, uopWord(rows[0]));
		waitIrq();
		expCount++;
		checkVal("irq", {31'b0, irq}, 32'h1);
		apbWrite(`REG_STATUS, 32'h2);
		// The interrupt is registered, so it drops one edge after DONE clears
		@(posedge clk);
		#1;
		checkVal("irq", {31'b0, irq}, 32'h0);
		apbWrite(`REG_CTRL, 32'h0);
		apbWrite(`REG_UOP, uopWord(rows[0]));
		waitIdle();
		expCount++;
		readCheck("STATUS", `REG_STATUS, 32'h2);
		checkVal("irq", {31'b0, irq}, 32'h0);
		apbWrite(`REG_STATUS, 32'h2);
		finishTest("interrupt");

		apbXfer(1'b1, `REG_RESULT, 32'hdead_beef, 1'b1, value);
		apbXfer(1'b1, `REG_COUNT, 32'h0000_0001, 1'b1, value);
		apbXfer(1'b0, 5'h1c, 32'h0, 1'b1, value);
		apbXfer(1'b1, 5'h1c, 32'h0, 1'b1, value);
		readCheck("RESULT", `REG_RESULT, refProduct(rows[0]));
		readCheck("COUNT", `REG_COUNT, expCount);
		finishTest("bus errors");

		$display("Summary: %0d tests run, %0d with errors, %0d check errors, %0d assertion errors",
			testCount, failedTests, errCount, dut.uChecker.failCount);
		if (errCount == 0 && dut.uChecker.failCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* mulIssue.f */
+incdir+.
mulIssuePkg.sv
decodeMul.sv
mulUnit.sv
mulRegs.sv
mulIssueTop.sv
mulIssue_checker.sv
mulIssueTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the multiply issue slice with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module mulIssueTb -f mulIssue.f -o mulIssueSim &&
./obj_dir/mulIssueSim | grep "Regression passed" ||
{ echo "Simulation did not report a pass"; exit 1; }
